// ==== src.f ====
axi_pkg.sv
aw_arbiter.sv
w_channel.sv
b_channel.sv
axi_write_bus.sv
axi_write_bus_chk.sv
axi_write_bus_tb.sv

// ==== axi_write_bus_tb.sv ====
`timescale 1ns/1ns

module axi_write_bus_tb;

	localparam int TMO = 200;   // cycles allowed for any single wait.

	logic             clk;
	logic             rst_n;
	axi_pkg::aw_req_t aw_m [2];
	logic             awvalid_m [2];
	logic             awready_m [2];
	axi_pkg::w_beat_t w_m [2];
	logic             wvalid_m [2];
	logic             wready_m [2];
	axi_pkg::b_rsp_t  b_m [2];
	logic             bvalid_m [2];
	logic             bready_m [2];
	axi_pkg::aw_req_t aw_s [2];
	logic             awvalid_s [2];
	logic             awready_s [2];
	axi_pkg::w_beat_t w_s [2];
	logic             wvalid_s [2];
	logic             wready_s [2];
	axi_pkg::b_rsp_t  b_s [2];
	logic             bvalid_s [2];
	logic             bready_s [2];

	// slave model state.
	axi_pkg::aw_req_t aw_got [2];
	int               beat_cnt [2];
	int               valid_cnt [2] = '{0, 0};
	bit               b_pend [2];
	int               b_wait [2];

	int               errors = 0;
	int               timeouts = 0;
	bit               arb_check = 1'b0;
	bit               gnt_last = 1'b0;
	int unsigned      lcg_state = 13;

	axi_write_bus uut (
		.clk(clk), .rst_n(rst_n),
		.aw_m0(aw_m[0]), .awvalid_m0(awvalid_m[0]), .awready_m0(awready_m[0]),
		.w_m0(w_m[0]), .wvalid_m0(wvalid_m[0]), .wready_m0(wready_m[0]),
		.b_m0(b_m[0]), .bvalid_m0(bvalid_m[0]), .bready_m0(bready_m[0]),
		.aw_m1(aw_m[1]), .awvalid_m1(awvalid_m[1]), .awready_m1(awready_m[1]),
		.w_m1(w_m[1]), .wvalid_m1(wvalid_m[1]), .wready_m1(wready_m[1]),
		.b_m1(b_m[1]), .bvalid_m1(bvalid_m[1]), .bready_m1(bready_m[1]),
		.aw_s0(aw_s[0]), .awvalid_s0(awvalid_s[0]), .awready_s0(awready_s[0]),
		.w_s0(w_s[0]), .wvalid_s0(wvalid_s[0]), .wready_s0(wready_s[0]),
		.b_s0(b_s[0]), .bvalid_s0(bvalid_s[0]), .bready_s0(bready_s[0]),
		.aw_s1(aw_s[1]), .awvalid_s1(awvalid_s[1]), .awready_s1(awready_s[1]),
		.w_s1(w_s[1]), .wvalid_s1(wvalid_s[1]), .wready_s1(wready_s[1]),
		.b_s1(b_s[1]), .bvalid_s1(bvalid_s[1]), .bready_s1(bready_s[1])
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state >> 8;
	endfunction

	function automatic axi_pkg::aw_req_t make_aw(input int m, input int seq,
			input axi_pkg::addr_t addr, input int len);
		axi_pkg::aw_req_t aw;
		aw.id    = {m[0], 3'(seq)};   // top ID bit names the issuing master.
		aw.addr  = addr;
		aw.len   = 8'(len);
		aw.size  = 3'd2;
		aw.burst = 2'b01;
		return aw;
	endfunction

	function automatic axi_pkg::w_beat_t make_beat(input axi_pkg::id_t id, input int i,
			input bit last);
		axi_pkg::w_beat_t b;
		b.data = {id, 12'h5a3, 8'(i), 8'(i * 37)};
		b.strb = 4'hf >> (i % 4);
		b.last = last;
		return b;
	endfunction

	task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] got);
		assert (got === exp) else begin
			errors++;
			$display("** Error: %s expected 0x%0h got 0x%0h", name, exp, got);
		end
	endtask

	task automatic report_timeout(input string what);
		timeouts++;
		$display("timeout while waiting for %s", what);
	endtask

	// ##########################################################
	// master side, entered and left just after a falling edge.
	// ##########################################################

	task automatic send_aw(input int m, input axi_pkg::aw_req_t aw, input bit lat);
		int t;
		int tgt;
		tgt = (aw.addr[31:16] < 2) ? int'(aw.addr[31:16]) : 2;
		aw_m[m]      = aw;
		awvalid_m[m] = 1'b1;
		for (t = 0; t < TMO; t++) begin
			@(posedge clk);
			if (lat && t < 2 && tgt < 2)
				check_eq("awvalid_s", t, awvalid_s[tgt]);   // grant edge, then the slave.
			if (awready_m[m])
				break;
		end
		if (t == TMO)
			report_timeout($sformatf("awready_m%0d", m));
		if (arb_check)
			check_eq("granted master", !gnt_last, m);
		gnt_last = m[0];
		@(negedge clk);
		awvalid_m[m] = 1'b0;
		aw_m[m]      = '0;
	endtask

	task automatic send_beat(input int m, input axi_pkg::w_beat_t beat);
		int t;
		w_m[m]      = beat;
		wvalid_m[m] = 1'b1;
		for (t = 0; t < TMO; t++) begin
			@(posedge clk);
			if (wready_m[m])
				break;
		end
		if (t == TMO)
			report_timeout($sformatf("wready_m%0d", m));
		@(negedge clk);
	endtask

	task automatic master_write(input int m, input axi_pkg::aw_req_t aw, input bit lat);
		int t;
		axi_pkg::resp_t exp_resp;
		exp_resp = (aw.addr[31:17] == 15'h0) ? axi_pkg::RESP_OKAY : axi_pkg::RESP_DECERR;
		send_aw(m, aw, lat);
		for (int i = 0; i <= aw.len; i++)
			send_beat(m, make_beat(aw.id, i, i == aw.len));
		wvalid_m[m] = 1'b0;
		w_m[m]      = '0;
		bready_m[m] = 1'b1;
		for (t = 0; t < TMO; t++) begin
			@(posedge clk);
			check_eq("bvalid of the other master", 0, bvalid_m[1 - m]);
			check_eq("b of the other master", 0, b_m[1 - m]);
			if (bvalid_m[m])
				break;
		end
		if (t == TMO)
			report_timeout($sformatf("bvalid_m%0d", m));
		check_eq($sformatf("b_m%0d.id", m), aw.id, b_m[m].id);
		check_eq($sformatf("b_m%0d.resp", m), exp_resp, b_m[m].resp);
		@(negedge clk);
		bready_m[m] = 1'b0;
	endtask

	// ##########################################################
	// slave models.
	// ##########################################################

	initial begin : slave_models
		int s;
		axi_pkg::w_beat_t exp;
		forever begin
			@(posedge clk);
			check_eq("awvalid_s to both slaves", 0, awvalid_s[0] && awvalid_s[1]);
			for (s = 0; s < 2; s++) begin
				if (!rst_n) begin
					b_pend[s]   = 1'b0;
					beat_cnt[s] = 0;
				end else begin
					if (awvalid_s[s] || wvalid_s[s])
						valid_cnt[s]++;   // any valid cycle, with or without ready.
					if (awvalid_s[s] && awready_s[s]) begin
						aw_got[s]   = aw_s[s];
						beat_cnt[s] = 0;
						check_eq("aw_s region", s, aw_s[s].addr[31:16]);
					end
					if (wvalid_s[s] && wready_s[s]) begin
						exp = make_beat(aw_got[s].id, beat_cnt[s], beat_cnt[s] == aw_got[s].len);
						check_eq($sformatf("w_s%0d", s), exp, w_s[s]);
						beat_cnt[s]++;
						if (w_s[s].last) begin
							check_eq("beat count", aw_got[s].len + 1, beat_cnt[s]);
							b_pend[s] = 1'b1;
							b_wait[s] = lcg_next() % 4;
						end
					end
					if (bvalid_s[s] && bready_s[s])
						b_pend[s] = 1'b0;
				end
			end
			@(negedge clk);
			for (s = 0; s < 2; s++) begin
				awready_s[s] = rst_n && (lcg_next() % 4 == 0);
				wready_s[s]  = rst_n && (lcg_next() % 3 != 0);
				bvalid_s[s]  = 1'b0;
				b_s[s]       = '0;
				if (rst_n && b_pend[s] && b_wait[s] == 0) begin
					bvalid_s[s] = 1'b1;   // held until the handshake.
					b_s[s].id   = aw_got[s].id;
					b_s[s].resp = axi_pkg::RESP_OKAY;
				end else if (b_wait[s] > 0) begin
					b_wait[s]--;
				end
			end
		end
	end

	// ##########################################################
	// test sequence.
	// ##########################################################

	initial begin : stimulus
		int n;
		rst_n = 1'b0;
		for (int m = 0; m < 2; m++) begin
			aw_m[m]      = '0;
			awvalid_m[m] = 1'b0;
			w_m[m]       = '0;
			wvalid_m[m]  = 1'b0;
			bready_m[m]  = 1'b0;
			awready_s[m] = 1'b0;
			wready_s[m]  = 1'b0;
			b_s[m]       = '0;
			bvalid_s[m]  = 1'b0;
		end
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		master_write(0, make_aw(0, 1, 32'h0000_0100, 3), 1'b1);
		master_write(1, make_aw(1, 2, 32'h0001_0040, 4), 1'b1);
		for (int i = 0; i < 4; i++)   // long bursts against random back-pressure.
			master_write(i % 2, make_aw(i % 2, 3 + i, {15'h0, i[1], 16'h0200}, 7), 1'b1);

		arb_check = 1'b1;
		for (int r = 0; r < 3; r++) begin
			// a lone write first, so the tie follows a grant to M0, then to M1.
			master_write(r % 2, make_aw(r % 2, 6, {15'h0, r[0], 16'h0600}, 1), 1'b0);
			fork
				master_write(0, make_aw(0, r, {15'h0, r[0], 16'h0400}, 2), 1'b0);
				master_write(1, make_aw(1, r, {15'h0, !r[0], 16'h0800}, 3), 1'b0);
			join
		end
		arb_check = 1'b0;

		n = valid_cnt[0] + valid_cnt[1];
		master_write(1, make_aw(1, 5, 32'h0005_0000, 2), 1'b1);
		check_eq("slave valid cycles after decode error", n, valid_cnt[0] + valid_cnt[1]);

		// reset in the middle of a burst.
		send_aw(0, make_aw(0, 6, 32'h0000_0300, 7), 1'b1);
		send_beat(0, make_beat(axi_pkg::id_t'(4'h6), 0, 1'b0));
		send_beat(0, make_beat(axi_pkg::id_t'(4'h6), 1, 1'b0));
		rst_n       = 1'b0;
		wvalid_m[0] = 1'b0;
		w_m[0]      = '0;
		@(posedge clk);
		@(negedge clk);
		check_eq("handshake outputs in reset", 0, {awready_m[0], awready_m[1], wready_m[0],
			wready_m[1], bvalid_m[0], bvalid_m[1], awvalid_s[0], awvalid_s[1],
			wvalid_s[0], wvalid_s[1], bready_s[0], bready_s[1]});
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
		master_write(0, make_aw(0, 7, 32'h0000_0500, 2), 1'b1);

		$display("checks failed: %0d in testbench, %0d in assertions; timeouts: %0d",
			errors, uut.u_chk.fails, timeouts);
		if (errors == 0 && timeouts == 0 && uut.u_chk.fails == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// ==== axi_write_bus_chk.sv ====
`timescale 1ns/1ns

module axi_write_bus_chk (
	input logic            clk,
	input logic            rst_n,
	input axi_pkg::owner_e owner,
	input logic            awready_m0,
	input logic            awready_m1,
	input logic            wready_m0,
	input logic            wready_m1,
	input logic            bvalid_m0,
	input logic            bvalid_m1,
	input logic            awvalid_s0,
	input logic            awvalid_s1,
	input logic            wvalid_s0,
	input logic            wvalid_s1,
	input logic            bready_s0,
	input logic            bready_s1
);

	int   fails = 0;
	logic quiet;

	assign quiet = !(awready_m0 || awready_m1 || wready_m0 || wready_m1 ||
		bvalid_m0 || bvalid_m1 || awvalid_s0 || awvalid_s1 ||
		wvalid_s0 || wvalid_s1 || bready_s0 || bready_s1);

	// ##########################################################
	// routing.
	// ##########################################################

	single_w: assert property (@(posedge clk) disable iff (!rst_n)
		!(wvalid_s0 && wvalid_s1))
		else begin fails++; $error("write data driven toward both slaves."); end

	m0_owner: assert property (@(posedge clk) disable iff (!rst_n)
		(owner == axi_pkg::OWN_M0) |-> (!wready_m1 && !bvalid_m1))
		else begin fails++; $error("M1 sees wready or bvalid while M0 owns the bus."); end

	m1_owner: assert property (@(posedge clk) disable iff (!rst_n)
		(owner == axi_pkg::OWN_M1) |-> (!wready_m0 && !bvalid_m0))
		else begin fails++; $error("M0 sees wready or bvalid while M1 owns the bus."); end

	// one edge into reset the state register is idle, so every handshake output is low.
	reset_quiet: assert property (@(posedge clk) !rst_n |=> (rst_n || quiet))
		else begin fails++; $error("valid or ready output high during reset."); end

endmodule

bind axi_write_bus axi_write_bus_chk u_chk (
	.clk(clk), .rst_n(rst_n), .owner(owner),
	.awready_m0(awready_m0), .awready_m1(awready_m1),
	.wready_m0(wready_m0), .wready_m1(wready_m1),
	.bvalid_m0(bvalid_m0), .bvalid_m1(bvalid_m1),
	.awvalid_s0(awvalid_s0), .awvalid_s1(awvalid_s1),
	.wvalid_s0(wvalid_s0), .wvalid_s1(wvalid_s1),
	.bready_s0(bready_s0), .bready_s1(bready_s1)
);

// ==== axi_write_bus.sv ====
`timescale 1ns/1ns

module axi_write_bus (
	input  logic             clk,
	input  logic             rst_n,

	// master 0.
	input  axi_pkg::aw_req_t aw_m0,
	input  logic             awvalid_m0,
	output logic             awready_m0,
	input  axi_pkg::w_beat_t w_m0,
	input  logic             wvalid_m0,
	output logic             wready_m0,
	output axi_pkg::b_rsp_t  b_m0,
	output logic             bvalid_m0,
	input  logic             bready_m0,

	// master 1.
	input  axi_pkg::aw_req_t aw_m1,
	input  logic             awvalid_m1,
	output logic             awready_m1,
	input  axi_pkg::w_beat_t w_m1,
	input  logic             wvalid_m1,
	output logic             wready_m1,
	output axi_pkg::b_rsp_t  b_m1,
	output logic             bvalid_m1,
	input  logic             bready_m1,

	// slave 0.
	output axi_pkg::aw_req_t aw_s0,
	output logic             awvalid_s0,
	input  logic             awready_s0,
	output axi_pkg::w_beat_t w_s0,
	output logic             wvalid_s0,
	input  logic             wready_s0,
	input  axi_pkg::b_rsp_t  b_s0,
	input  logic             bvalid_s0,
	output logic             bready_s0,

	// slave 1.
	output axi_pkg::aw_req_t aw_s1,
	output logic             awvalid_s1,
	input  logic             awready_s1,
	output axi_pkg::w_beat_t w_s1,
	output logic             wvalid_s1,
	input  logic             wready_s1,
	input  axi_pkg::b_rsp_t  b_s1,
	input  logic             bvalid_s1,
	output logic             bready_s1
);

	axi_pkg::wstate_e wstate;
	axi_pkg::owner_e  owner;
	axi_pkg::slave_e  slave;
	axi_pkg::id_t     err_id;
	logic             wlast_done;
	logic             b_done;

	aw_arbiter #(
		.S0_REGION(16'h0000),
		.S1_REGION(16'h0001)
	) u_aw_arbiter (
		.clk(clk), .rst_n(rst_n),
		.aw_m0(aw_m0), .awvalid_m0(awvalid_m0), .awready_m0(awready_m0),
		.aw_m1(aw_m1), .awvalid_m1(awvalid_m1), .awready_m1(awready_m1),
		.aw_s0(aw_s0), .awvalid_s0(awvalid_s0), .awready_s0(awready_s0),
		.aw_s1(aw_s1), .awvalid_s1(awvalid_s1), .awready_s1(awready_s1),
		.wlast_done(wlast_done), .b_done(b_done),
		.wstate(wstate), .owner(owner), .slave(slave), .err_id(err_id)
	);

	w_channel u_w_channel (
		.wstate(wstate), .owner(owner), .slave(slave),
		.w_m0(w_m0), .wvalid_m0(wvalid_m0), .wready_m0(wready_m0),
		.w_m1(w_m1), .wvalid_m1(wvalid_m1), .wready_m1(wready_m1),
		.w_s0(w_s0), .wvalid_s0(wvalid_s0), .wready_s0(wready_s0),
		.w_s1(w_s1), .wvalid_s1(wvalid_s1), .wready_s1(wready_s1),
		.wlast_done(wlast_done)
	);

	b_channel u_b_channel (
		.wstate(wstate), .slave(slave), .owner(owner), .err_id(err_id),
		.b_s0(b_s0), .bvalid_s0(bvalid_s0), .bready_s0(bready_s0),
		.b_s1(b_s1), .bvalid_s1(bvalid_s1), .bready_s1(bready_s1),
		.b_m0(b_m0), .bvalid_m0(bvalid_m0), .bready_m0(bready_m0),
		.b_m1(b_m1), .bvalid_m1(bvalid_m1), .bready_m1(bready_m1),
		.b_done(b_done)
	);

endmodule

// ==== b_channel.sv ====
`timescale 1ns/1ns

module b_channel (
	input  axi_pkg::wstate_e wstate,
	input  axi_pkg::slave_e  slave,
	input  axi_pkg::owner_e  owner,
	input  axi_pkg::id_t     err_id,

	input  axi_pkg::b_rsp_t  b_s0,
	input  logic             bvalid_s0,
	output logic             bready_s0,

	input  axi_pkg::b_rsp_t  b_s1,
	input  logic             bvalid_s1,
	output logic             bready_s1,

	output axi_pkg::b_rsp_t  b_m0,
	output logic             bvalid_m0,
	input  logic             bready_m0,

	output axi_pkg::b_rsp_t  b_m1,
	output logic             bvalid_m1,
	input  logic             bready_m1,

	output logic             b_done
);

	axi_pkg::b_rsp_t rsp;
	logic            bvalid_bus;
	logic            bready_bus;

	// the owner's bready goes back toward the slave.
	assign bready_bus = (owner == axi_pkg::OWN_M1) ? bready_m1 : bready_m0;

	// ##########################################################
	// response select.
	// ##########################################################

	always_comb begin
		rsp        = '0;
		bvalid_bus = 1'b0;
		bready_s0  = 1'b0;
		bready_s1  = 1'b0;
		if (wstate == axi_pkg::W_RESP) begin
			case (slave)
				axi_pkg::SLAVE0: begin
					rsp        = b_s0;
					bvalid_bus = bvalid_s0;
					bready_s0  = bready_bus;
				end
				axi_pkg::SLAVE1: begin
					rsp        = b_s1;
					bvalid_bus = bvalid_s1;
					bready_s1  = bready_bus;
				end
				default: begin
					rsp.id     = err_id;   // decode error answered by the interconnect.
					rsp.resp   = axi_pkg::RESP_DECERR;
					bvalid_bus = 1'b1;
				end
			endcase
		end
	end

	// only the owning master sees the response.
	assign b_m0      = (owner == axi_pkg::OWN_M0) ? rsp : '0;
	assign b_m1      = (owner == axi_pkg::OWN_M1) ? rsp : '0;
	assign bvalid_m0 = (owner == axi_pkg::OWN_M0) && bvalid_bus;
	assign bvalid_m1 = (owner == axi_pkg::OWN_M1) && bvalid_bus;

	assign b_done = bvalid_bus && bready_bus;

endmodule

// ==== w_channel.sv ====
`timescale 1ns/1ns

module w_channel (
	input  axi_pkg::wstate_e wstate,
	input  axi_pkg::owner_e  owner,
	input  axi_pkg::slave_e  slave,

	input  axi_pkg::w_beat_t w_m0,
	input  logic             wvalid_m0,
	output logic             wready_m0,

	input  axi_pkg::w_beat_t w_m1,
	input  logic             wvalid_m1,
	output logic             wready_m1,

	output axi_pkg::w_beat_t w_s0,
	output logic             wvalid_s0,
	input  logic             wready_s0,

	output axi_pkg::w_beat_t w_s1,
	output logic             wvalid_s1,
	input  logic             wready_s1,

	output logic             wlast_done
);

	axi_pkg::w_beat_t beat;
	logic             wvalid_bus;
	logic             wready_bus;

	// ##########################################################
	// master side.
	// ##########################################################

	always_comb begin
		beat       = '0;
		wvalid_bus = 1'b0;
		wready_m0  = 1'b0;
		wready_m1  = 1'b0;
		if (wstate == axi_pkg::W_DATA) begin
			case (owner)
				axi_pkg::OWN_M0: begin
					beat       = w_m0;
					wvalid_bus = wvalid_m0;
					wready_m0  = wready_bus;
				end
				default: begin
					beat       = w_m1;
					wvalid_bus = wvalid_m1;
					wready_m1  = wready_bus;
				end
			endcase
		end
	end

	// ##########################################################
	// slave side.
	// ##########################################################

	always_comb begin
		w_s0       = '0;
		w_s1       = '0;
		wvalid_s0  = 1'b0;
		wvalid_s1  = 1'b0;
		wready_bus = 1'b0;
		case (slave)
			axi_pkg::SLAVE0: begin
				w_s0       = beat;
				wvalid_s0  = wvalid_bus;
				wready_bus = wready_s0;
			end
			axi_pkg::SLAVE1: begin
				w_s1       = beat;
				wvalid_s1  = wvalid_bus;
				wready_bus = wready_s1;
			end
			axi_pkg::SLAVE_NONE: wready_bus = 1'b1;   // beats are dropped here.
			default: wready_bus = 1'b0;
		endcase
	end

	// the closing beat of the burst hands the channel to the response phase.
	assign wlast_done = wvalid_bus && wready_bus && beat.last;

endmodule

// ==== aw_arbiter.sv ====
`timescale 1ns/1ns

module aw_arbiter #(
	parameter axi_pkg::region_t S0_REGION = 16'h0000,
	parameter axi_pkg::region_t S1_REGION = 16'h0001
) (
	input  logic             clk,
	input  logic             rst_n,

	input  axi_pkg::aw_req_t aw_m0,
	input  logic             awvalid_m0,
	output logic             awready_m0,

	input  axi_pkg::aw_req_t aw_m1,
	input  logic             awvalid_m1,
	output logic             awready_m1,

	output axi_pkg::aw_req_t aw_s0,
	output logic             awvalid_s0,
	input  logic             awready_s0,

	output axi_pkg::aw_req_t aw_s1,
	output logic             awvalid_s1,
	input  logic             awready_s1,

	input  logic             wlast_done,
	input  logic             b_done,

	output axi_pkg::wstate_e wstate,
	output axi_pkg::owner_e  owner,
	output axi_pkg::slave_e  slave,
	output axi_pkg::id_t     err_id
);

	axi_pkg::wstate_e wstate_next;
	axi_pkg::owner_e  winner;
	axi_pkg::aw_req_t aw_win;
	axi_pkg::aw_req_t aw_own;
	logic             awvalid_own;
	logic             awready_own;
	logic             grant;
	logic             aw_done;

	// maps the upper address bits onto a slave.
	function automatic axi_pkg::slave_e decode(input axi_pkg::addr_t addr);
		axi_pkg::region_t region;
		region = addr[axi_pkg::ADDR_W-1 -: axi_pkg::REGION_W];
		if (region == S0_REGION)
			return axi_pkg::SLAVE0;
		else if (region == S1_REGION)
			return axi_pkg::SLAVE1;
		else
			return axi_pkg::SLAVE_NONE;
	endfunction

	// ##########################################################
	// grant.
	// ##########################################################

	// the owner register still holds the last grant while idle, so a tie
	// goes to the other master.
	always_comb begin
		if (awvalid_m0 && awvalid_m1)
			winner = (owner == axi_pkg::OWN_M0) ? axi_pkg::OWN_M1 : axi_pkg::OWN_M0;
		else if (awvalid_m1)
			winner = axi_pkg::OWN_M1;
		else
			winner = axi_pkg::OWN_M0;
	end

	assign aw_win = (winner == axi_pkg::OWN_M1) ? aw_m1 : aw_m0;
	assign grant  = (wstate == axi_pkg::W_IDLE) && (awvalid_m0 || awvalid_m1);

	// ##########################################################
	// address forwarding.
	// ##########################################################

	assign aw_own      = (owner == axi_pkg::OWN_M1) ? aw_m1 : aw_m0;
	assign awvalid_own = (owner == axi_pkg::OWN_M1) ? awvalid_m1 : awvalid_m0;

	always_comb begin
		aw_s0       = '0;
		aw_s1       = '0;
		awvalid_s0  = 1'b0;
		awvalid_s1  = 1'b0;
		awready_own = 1'b0;
		if (wstate == axi_pkg::W_AW) begin
			case (slave)
				axi_pkg::SLAVE0: begin
					aw_s0       = aw_own;
					awvalid_s0  = awvalid_own;
					awready_own = awready_s0;
				end
				axi_pkg::SLAVE1: begin
					aw_s1       = aw_own;
					awvalid_s1  = awvalid_own;
					awready_own = awready_s1;
				end
				default: awready_own = 1'b1;   // no slave, so the address is absorbed here.
			endcase
		end
	end

	assign awready_m0 = (owner == axi_pkg::OWN_M0) ? awready_own : 1'b0;
	assign awready_m1 = (owner == axi_pkg::OWN_M1) ? awready_own : 1'b0;
	assign aw_done    = awvalid_own && awready_own;

	// ##########################################################
	// write state machine.
	// ##########################################################

	always_comb begin
		wstate_next = wstate;
		case (wstate)
			axi_pkg::W_IDLE: if (grant) wstate_next = axi_pkg::W_AW;
			axi_pkg::W_AW:   if (aw_done) wstate_next = axi_pkg::W_DATA;
			axi_pkg::W_DATA: if (wlast_done) wstate_next = axi_pkg::W_RESP;
			axi_pkg::W_RESP: if (b_done) wstate_next = axi_pkg::W_IDLE;
			default:         wstate_next = axi_pkg::W_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wstate <= axi_pkg::W_IDLE;
			owner  <= axi_pkg::OWN_M1;   // lets M0 win the first tie.
			slave  <= axi_pkg::SLAVE_NONE;
		end else begin
			wstate <= wstate_next;
			if (grant) begin
				owner <= winner;
				slave <= decode(aw_win.addr);
			end
		end
	end

	// the ID is only needed for a decode error response.
	always_ff @(posedge clk) begin
		if (grant)
			err_id <= aw_win.id;
	end

endmodule

// ==== axi_pkg.sv ====
package axi_pkg;

	// ##########################################################
	// bus widths.
	// ##########################################################

	localparam int ADDR_W   = 32;
	localparam int DATA_W   = 32;
	localparam int STRB_W   = DATA_W / 8;
	localparam int ID_W     = 4;
	localparam int LEN_W    = 8;
	localparam int RESP_W   = 2;
	localparam int REGION_W = 16;   // upper address bits used by the decoder.

	typedef logic [ADDR_W-1:0]   addr_t;
	typedef logic [DATA_W-1:0]   data_t;
	typedef logic [STRB_W-1:0]   strb_t;
	typedef logic [ID_W-1:0]     id_t;
	typedef logic [LEN_W-1:0]    len_t;     // beats in the burst minus one.
	typedef logic [RESP_W-1:0]   resp_t;
	typedef logic [REGION_W-1:0] region_t;

	localparam resp_t RESP_OKAY   = 2'd0;
	localparam resp_t RESP_DECERR = 2'd3;

	// ##########################################################
	// channel payloads.
	// ##########################################################

	typedef struct packed {
		id_t        id;
		addr_t      addr;
		len_t       len;
		logic [2:0] size;
		logic [1:0] burst;
	} aw_req_t;

	typedef struct packed {
		data_t data;
		strb_t strb;
		logic  last;
	} w_beat_t;

	typedef struct packed {
		id_t   id;
		resp_t resp;
	} b_rsp_t;

	// ##########################################################
	// write path control.
	// ##########################################################

	typedef enum logic [2:0] {
		W_IDLE = 3'd0,
		W_AW   = 3'd1,
		W_DATA = 3'd2,
		W_RESP = 3'd3
	} wstate_e;

	typedef enum logic {
		OWN_M0 = 1'b0,
		OWN_M1 = 1'b1
	} owner_e;

	// SLAVE_NONE marks an address outside both regions.
	typedef enum logic [1:0] {
		SLAVE0     = 2'd0,
		SLAVE1     = 2'd1,
		SLAVE_NONE = 2'd2
	} slave_e;

endpackage
